/* include/fabric_soc_macros.svh */
// ##############################
// Bus widths, address map,
// device IDs and map sizes
// ##############################
`ifndef FABRIC_SOC_MACROS_SVH
`define FABRIC_SOC_MACROS_SVH

`define DATA_W      32
`define SEL_W       (`DATA_W / 8)
`define ADDR_W      16
`define GPIO_W      8
`define SRAM_DEPTH  1024

// Word addresses of the slave windows
`define DEVTBL_BASE 16'h0000
`define GPIO_BASE   16'h0010
`define DMA_BASE    16'h0020
`define SRAM_BASE   16'h1000
`define REG_SPAN    16

`define ID_INVALID  0
`define ID_SRAM     1
`define ID_DMA      2
`define ID_GPIO     6
`define ID_DEVTBL   7

// Map sizes in bytes
`define MAPSZ_REG     64
`define MAPSZ_SRAM    4096
`define MAPSZ_INVALID 0

`endif

/* design/fabric_soc_pkg.sv */
// ##############################
// Bus op codes and slave
// positions of the fabric
// ##############################
`default_nettype none

package fabric_soc_pkg;

	// No read-write swap op on this bus
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} bus_op_t;

	// Default responder sits in the last slot
	typedef enum logic [2:0] {
		SLV_DEVTBL  = 3'd0,
		SLV_GPIO    = 3'd1,
		SLV_DMA     = 3'd2,
		SLV_SRAM    = 3'd3,
		SLV_INVALID = 3'd4
	} slave_idx_t;

	localparam int SLAVE_COUNT = 5;

endpackage

`default_nettype wire

/* design/bus_arbiter.sv */
// ##############################
// Fixed-priority arbiter
// Host over DMA, one transaction
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module bus_arbiter
	import fabric_soc_pkg::*;
(
	input  logic               clk100mhz_i,
	input  logic               rst_p,
	input  logic               host_valid_i,
	input  bus_op_t            host_op_i,
	input  logic [`ADDR_W-1:0] host_addr_i,
	input  logic [`DATA_W-1:0] host_wdata_i,
	input  logic [`SEL_W-1:0]  host_sel_i,
	output logic               host_ready_o,
	output logic [`DATA_W-1:0] host_rdata_o,
	input  logic               dma_valid_i,
	input  bus_op_t            dma_op_i,
	input  logic [`ADDR_W-1:0] dma_addr_i,
	input  logic [`DATA_W-1:0] dma_wdata_i,
	input  logic [`SEL_W-1:0]  dma_sel_i,
	output logic               dma_ready_o,
	output logic [`DATA_W-1:0] dma_rdata_o,
	output logic               bus_valid_o,
	output bus_op_t            bus_op_o,
	output logic [`ADDR_W-1:0] bus_addr_o,
	output logic [`DATA_W-1:0] bus_wdata_o,
	output logic [`SEL_W-1:0]  bus_sel_o,
	input  logic               bus_ready_i,
	input  logic [`DATA_W-1:0] bus_rdata_i
);

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_HOST,
		OWN_DMA
	} owner_t;

	owner_t owner_q;

	// Grant only from idle, host first; release on the slave's ready
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			owner_q <= OWN_NONE;
		end else if (owner_q == OWN_NONE) begin
			if (host_valid_i) begin
				owner_q <= OWN_HOST;
			end else if (dma_valid_i) begin
				owner_q <= OWN_DMA;
			end
		end else if (bus_ready_i) begin
			owner_q <= OWN_NONE;
		end
	end

	always_comb begin
		bus_valid_o = 1'b0;
		bus_op_o    = OP_NONE;
		bus_addr_o  = '0;
		bus_wdata_o = '0;
		bus_sel_o   = '0;
		case (owner_q)
			OWN_HOST: begin
				bus_valid_o = host_valid_i;
				bus_op_o    = host_op_i;
				bus_addr_o  = host_addr_i;
				bus_wdata_o = host_wdata_i;
				bus_sel_o   = host_sel_i;
			end
			OWN_DMA: begin
				bus_valid_o = dma_valid_i;
				bus_op_o    = dma_op_i;
				bus_addr_o  = dma_addr_i;
				bus_wdata_o = dma_wdata_i;
				bus_sel_o   = dma_sel_i;
			end
			default: begin
				bus_valid_o = 1'b0;
			end
		endcase
	end

	// Reply goes back to the owner only
	assign host_ready_o = (owner_q == OWN_HOST) && bus_ready_i;
	assign host_rdata_o = (owner_q == OWN_HOST) ? bus_rdata_i : '0;
	assign dma_ready_o  = (owner_q == OWN_DMA) && bus_ready_i;
	assign dma_rdata_o  = (owner_q == OWN_DMA) ? bus_rdata_i : '0;

endmodule

`default_nettype wire

/* design/addr_decoder.sv */
// ##############################
// Address decoder, reply mux
// and invalid address responder
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module addr_decoder
	import fabric_soc_pkg::*;
(
	input  logic                   clk100mhz_i,
	input  logic                   rst_p,
	input  logic                   bus_valid_i,
	input  bus_op_t                bus_op_i,
	input  logic [`ADDR_W-1:0]     bus_addr_i,
	input  logic [`DATA_W-1:0]     bus_wdata_i,
	input  logic [`SEL_W-1:0]      bus_sel_i,
	output logic                   bus_ready_o,
	output logic [`DATA_W-1:0]     bus_rdata_o,
	output logic [SLAVE_COUNT-1:0] slv_sel_o,
	output bus_op_t                slv_op_o,
	output logic [`ADDR_W-1:0]     slv_addr_o,
	output logic [`DATA_W-1:0]     slv_wdata_o,
	output logic [`SEL_W-1:0]      slv_sel_bytes_o,
	input  logic                   devtbl_ready_i,
	input  logic [`DATA_W-1:0]     devtbl_rdata_i,
	input  logic                   gpio_ready_i,
	input  logic [`DATA_W-1:0]     gpio_rdata_i,
	input  logic                   dma_ready_i,
	input  logic [`DATA_W-1:0]     dma_rdata_i,
	input  logic                   sram_ready_i,
	input  logic [`DATA_W-1:0]     sram_rdata_i
);

	slave_idx_t             slv_idx;
	logic [`ADDR_W-1:0]     base_addr;
	logic [SLAVE_COUNT-1:0] rdy_vec;
	logic                   inv_ready_q;

	function automatic logic in_window(
		input logic [`ADDR_W-1:0] addr,
		input logic [`ADDR_W-1:0] base,
		input int                 span
	);
		return (int'(addr) >= int'(base)) && (int'(addr) < int'(base) + span);
	endfunction

	// Anything outside the four windows lands on the default responder
	always_comb begin
		slv_idx   = SLV_INVALID;
		base_addr = '0;
		if (in_window(bus_addr_i, `DEVTBL_BASE, `REG_SPAN)) begin
			slv_idx   = SLV_DEVTBL;
			base_addr = `DEVTBL_BASE;
		end else if (in_window(bus_addr_i, `GPIO_BASE, `REG_SPAN)) begin
			slv_idx   = SLV_GPIO;
			base_addr = `GPIO_BASE;
		end else if (in_window(bus_addr_i, `DMA_BASE, `REG_SPAN)) begin
			slv_idx   = SLV_DMA;
			base_addr = `DMA_BASE;
		end else if (in_window(bus_addr_i, `SRAM_BASE, `SRAM_DEPTH)) begin
			slv_idx   = SLV_SRAM;
			base_addr = `SRAM_BASE;
		end
	end

	// Select stays up while the owner holds its request
	assign slv_sel_o       = bus_valid_i ? (SLAVE_COUNT'(1) << slv_idx) : '0;
	assign slv_op_o        = bus_op_i;
	assign slv_addr_o      = bus_addr_i - base_addr;
	assign slv_wdata_o     = bus_wdata_i;
	assign slv_sel_bytes_o = bus_sel_i;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			inv_ready_q <= 1'b0;
		end else begin
			inv_ready_q <= slv_sel_o[SLV_INVALID] && !inv_ready_q;
		end
	end

	// Packed in slave_idx_t order, MSB is the invalid slot
	assign rdy_vec = {inv_ready_q, sram_ready_i, dma_ready_i, gpio_ready_i, devtbl_ready_i};

	assign bus_ready_o = bus_valid_i && rdy_vec[slv_idx];

	always_comb begin
		case (slv_idx)
			SLV_DEVTBL: bus_rdata_o = devtbl_rdata_i;
			SLV_GPIO:   bus_rdata_o = gpio_rdata_i;
			SLV_DMA:    bus_rdata_o = dma_rdata_i;
			SLV_SRAM:   bus_rdata_o = sram_rdata_i;
			default:    bus_rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/dma_engine.sv */
// ##############################
// Single-channel DMA engine
// Register slave and copy FSM
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module dma_engine
	import fabric_soc_pkg::*;
(
	input  logic               clk100mhz_i,
	input  logic               rst_p,
	input  logic               sel_i,
	input  bus_op_t            op_i,
	input  logic [`ADDR_W-1:0] addr_i,
	input  logic [`DATA_W-1:0] wdata_i,
	input  logic [`SEL_W-1:0]  sel_bytes_i,
	output logic               ready_o,
	output logic [`DATA_W-1:0] rdata_o,
	output logic               m_valid_o,
	output bus_op_t            m_op_o,
	output logic [`ADDR_W-1:0] m_addr_o,
	output logic [`DATA_W-1:0] m_wdata_o,
	output logic [`SEL_W-1:0]  m_sel_o,
	input  logic               m_ready_i,
	input  logic [`DATA_W-1:0] m_rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE
	} dma_state_t;

	localparam logic [`ADDR_W-1:0] REG_SRC  = `ADDR_W'(0);
	localparam logic [`ADDR_W-1:0] REG_DST  = `ADDR_W'(1);
	localparam logic [`ADDR_W-1:0] REG_CNT  = `ADDR_W'(2);
	localparam logic [`ADDR_W-1:0] REG_CTRL = `ADDR_W'(3);

	dma_state_t         state_q;
	logic [`DATA_W-1:0] src_q;
	logic [`DATA_W-1:0] dst_q;
	logic [`DATA_W-1:0] cnt_q;
	logic [`DATA_W-1:0] word_q;
	logic               busy;
	logic               reg_wr;
	logic               start;

	function automatic logic [`DATA_W-1:0] merge_bytes(
		input logic [`DATA_W-1:0] old_val,
		input logic [`DATA_W-1:0] new_val,
		input logic [`SEL_W-1:0]  sel
	);
		logic [`DATA_W-1:0] res;
		res = old_val;
		for (int b = 0; b < `SEL_W; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_val[8*b +: 8];
			end
		end
		return res;
	endfunction

	assign busy   = (state_q != ST_IDLE);
	assign reg_wr = sel_i && !ready_o && (op_i == OP_WRITE);
	assign start  = reg_wr && (addr_i == REG_CTRL) && sel_bytes_i[0] && wdata_i[0];

	always_ff @(posedge clk100mhz_i) begin
		case (addr_i)
			REG_SRC:  rdata_o <= src_q;
			REG_DST:  rdata_o <= dst_q;
			REG_CNT:  rdata_o <= cnt_q;
			REG_CTRL: rdata_o <= `DATA_W'(busy);
			default:  rdata_o <= '0;
		endcase
	end

	always_ff @(posedge clk100mhz_i) begin
		if (state_q == ST_READ && m_ready_i) begin
			word_q <= m_rdata_i;
		end
	end

	// Copy FSM steps the programmed registers, so they read back the progress
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			ready_o <= 1'b0;
			state_q <= ST_IDLE;
			src_q   <= '0;
			dst_q   <= '0;
			cnt_q   <= '0;
		end else begin
			ready_o <= sel_i && !ready_o;
			if (reg_wr && addr_i == REG_SRC) begin
				src_q <= merge_bytes(src_q, wdata_i, sel_bytes_i);
			end
			if (reg_wr && addr_i == REG_DST) begin
				dst_q <= merge_bytes(dst_q, wdata_i, sel_bytes_i);
			end
			if (reg_wr && addr_i == REG_CNT) begin
				cnt_q <= merge_bytes(cnt_q, wdata_i, sel_bytes_i);
			end
			case (state_q)
				ST_IDLE: begin
					// A zero count never starts
					if (start && cnt_q != '0) begin
						state_q <= ST_READ;
					end
				end
				ST_READ: begin
					if (m_ready_i) begin
						state_q <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					if (m_ready_i) begin
						src_q   <= src_q + `DATA_W'(1);
						dst_q   <= dst_q + `DATA_W'(1);
						cnt_q   <= cnt_q - `DATA_W'(1);
						state_q <= (cnt_q == `DATA_W'(1)) ? ST_IDLE : ST_READ;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	assign m_valid_o = busy;
	assign m_op_o    = (state_q == ST_WRITE) ? OP_WRITE : (busy ? OP_READ : OP_NONE);
	assign m_addr_o  = (state_q == ST_WRITE) ? dst_q[`ADDR_W-1:0] : src_q[`ADDR_W-1:0];
	assign m_wdata_o = word_q;
	assign m_sel_o   = '1;

endmodule

`default_nettype wire

/* design/device_table.sv */
// ##############################
// Read-only device table
// IDs and map sizes per slave
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module device_table
	import fabric_soc_pkg::*;
(
	input  logic               clk100mhz_i,
	input  logic               rst_p,
	input  logic               sel_i,
	input  bus_op_t            op_i,
	input  logic [`ADDR_W-1:0] addr_i,
	output logic               ready_o,
	output logic [`DATA_W-1:0] rdata_o
);

	logic [`DATA_W-1:0] rd_word;

	function automatic logic [`DATA_W-1:0] dev_id(input slave_idx_t idx);
		case (idx)
			SLV_DEVTBL: return `DATA_W'(`ID_DEVTBL);
			SLV_GPIO:   return `DATA_W'(`ID_GPIO);
			SLV_DMA:    return `DATA_W'(`ID_DMA);
			SLV_SRAM:   return `DATA_W'(`ID_SRAM);
			default:    return `DATA_W'(`ID_INVALID);
		endcase
	endfunction

	function automatic logic [`DATA_W-1:0] map_size(input slave_idx_t idx);
		case (idx)
			SLV_SRAM:    return `DATA_W'(`MAPSZ_SRAM);
			SLV_INVALID: return `DATA_W'(`MAPSZ_INVALID);
			default:     return `DATA_W'(`MAPSZ_REG);
		endcase
	endfunction

	// IDs at words 0.., map sizes at words 8..
	always_comb begin
		rd_word = '0;
		if (addr_i < `ADDR_W'(SLAVE_COUNT)) begin
			rd_word = dev_id(slave_idx_t'(addr_i[2:0]));
		end else if (addr_i >= `ADDR_W'(8) && addr_i < `ADDR_W'(8 + SLAVE_COUNT)) begin
			rd_word = map_size(slave_idx_t'(addr_i[2:0]));
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			ready_o <= 1'b0;
		end else begin
			ready_o <= sel_i && !ready_o;
		end
	end

	// Writes complete with nothing stored
	always_ff @(posedge clk100mhz_i) begin
		rdata_o <= (op_i == OP_READ) ? rd_word : '0;
	end

endmodule

`default_nettype wire

/* design/gpio_port.sv */
// ##############################
// GPIO slave, synchronized
// inputs and output register
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module gpio_port
	import fabric_soc_pkg::*;
(
	input  logic               clk100mhz_i,
	input  logic               rst_p,
	input  logic               sel_i,
	input  bus_op_t            op_i,
	input  logic [`ADDR_W-1:0] addr_i,
	input  logic [`DATA_W-1:0] wdata_i,
	input  logic [`SEL_W-1:0]  sel_bytes_i,
	output logic               ready_o,
	output logic [`DATA_W-1:0] rdata_o,
	input  logic [`GPIO_W-1:0] gp_i,
	output logic [`GPIO_W-1:0] gp_o
);

	logic [`GPIO_W-1:0] gp_meta_q;
	logic [`GPIO_W-1:0] gp_sync_q;

	// Two flops against metastability on the pins
	always_ff @(posedge clk100mhz_i) begin
		gp_meta_q <= gp_i;
		gp_sync_q <= gp_meta_q;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			ready_o <= 1'b0;
			gp_o    <= '0;
		end else begin
			ready_o <= sel_i && !ready_o;
			if (sel_i && !ready_o && op_i == OP_WRITE && addr_i == `ADDR_W'(1)
				&& sel_bytes_i[0]) begin
				gp_o <= wdata_i[`GPIO_W-1:0];
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		case (addr_i)
			`ADDR_W'(0): rdata_o <= `DATA_W'(gp_sync_q);
			`ADDR_W'(1): rdata_o <= `DATA_W'(gp_o);
			default:     rdata_o <= '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/sram_slave.sv */
// ##############################
// On-chip SRAM slave
// Byte-select writes
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module sram_slave
	import fabric_soc_pkg::*;
(
	input  logic               clk100mhz_i,
	input  logic               sel_i,
	input  bus_op_t            op_i,
	input  logic [`ADDR_W-1:0] addr_i,
	input  logic [`DATA_W-1:0] wdata_i,
	input  logic [`SEL_W-1:0]  sel_bytes_i,
	output logic               ready_o,
	output logic [`DATA_W-1:0] rdata_o
);

	localparam int IDX_W = $clog2(`SRAM_DEPTH);

	logic [`DATA_W-1:0] mem [`SRAM_DEPTH];
	logic [IDX_W-1:0]   idx;

	assign idx = addr_i[IDX_W-1:0];

	// Ready drops on its own since the select holds only until ready
	always_ff @(posedge clk100mhz_i) begin
		ready_o <= sel_i && !ready_o;
		if (sel_i && !ready_o && op_i == OP_WRITE) begin
			for (int b = 0; b < `SEL_W; b++) begin
				if (sel_bytes_i[b]) begin
					mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end
		rdata_o <= mem[idx];
	end

endmodule

`default_nettype wire

/* design/fabric_soc.sv */
// ##############################
// Bus fabric top level
// Arbiter, decoder and slaves
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module fabric_soc
	import fabric_soc_pkg::*;
(
	input  logic               clk100mhz_i,
	input  logic               rst_p,
	input  logic               host_valid_i,
	input  bus_op_t            host_op_i,
	input  logic [`ADDR_W-1:0] host_addr_i,
	input  logic [`DATA_W-1:0] host_wdata_i,
	input  logic [`SEL_W-1:0]  host_sel_i,
	output logic               host_ready_o,
	output logic [`DATA_W-1:0] host_rdata_o,
	input  logic [`GPIO_W-1:0] gp_i,
	output logic [`GPIO_W-1:0] gp_o
);

	// DMA as a master
	logic                   dma_m_valid;
	bus_op_t                dma_m_op;
	logic [`ADDR_W-1:0]     dma_m_addr;
	logic [`DATA_W-1:0]     dma_m_wdata;
	logic [`SEL_W-1:0]      dma_m_sel;
	logic                   dma_m_ready;
	logic [`DATA_W-1:0]     dma_m_rdata;

	logic                   bus_valid;
	bus_op_t                bus_op;
	logic [`ADDR_W-1:0]     bus_addr;
	logic [`DATA_W-1:0]     bus_wdata;
	logic [`SEL_W-1:0]      bus_sel;
	logic                   bus_ready;
	logic [`DATA_W-1:0]     bus_rdata;

	logic [SLAVE_COUNT-1:0] slv_sel;
	bus_op_t                slv_op;
	logic [`ADDR_W-1:0]     slv_addr;
	logic [`DATA_W-1:0]     slv_wdata;
	logic [`SEL_W-1:0]      slv_sel_bytes;

	logic                   devtbl_ready;
	logic [`DATA_W-1:0]     devtbl_rdata;
	logic                   gpio_ready;
	logic [`DATA_W-1:0]     gpio_rdata;
	logic                   dma_s_ready;
	logic [`DATA_W-1:0]     dma_s_rdata;
	logic                   sram_ready;
	logic [`DATA_W-1:0]     sram_rdata;

	bus_arbiter u_arbiter (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.host_valid_i (host_valid_i),
		.host_op_i    (host_op_i),
		.host_addr_i  (host_addr_i),
		.host_wdata_i (host_wdata_i),
		.host_sel_i   (host_sel_i),
		.host_ready_o (host_ready_o),
		.host_rdata_o (host_rdata_o),
		.dma_valid_i  (dma_m_valid),
		.dma_op_i     (dma_m_op),
		.dma_addr_i   (dma_m_addr),
		.dma_wdata_i  (dma_m_wdata),
		.dma_sel_i    (dma_m_sel),
		.dma_ready_o  (dma_m_ready),
		.dma_rdata_o  (dma_m_rdata),
		.bus_valid_o  (bus_valid),
		.bus_op_o     (bus_op),
		.bus_addr_o   (bus_addr),
		.bus_wdata_o  (bus_wdata),
		.bus_sel_o    (bus_sel),
		.bus_ready_i  (bus_ready),
		.bus_rdata_i  (bus_rdata)
	);

	addr_decoder u_decoder (
		.clk100mhz_i     (clk100mhz_i),
		.rst_p           (rst_p),
		.bus_valid_i     (bus_valid),
		.bus_op_i        (bus_op),
		.bus_addr_i      (bus_addr),
		.bus_wdata_i     (bus_wdata),
		.bus_sel_i       (bus_sel),
		.bus_ready_o     (bus_ready),
		.bus_rdata_o     (bus_rdata),
		.slv_sel_o       (slv_sel),
		.slv_op_o        (slv_op),
		.slv_addr_o      (slv_addr),
		.slv_wdata_o     (slv_wdata),
		.slv_sel_bytes_o (slv_sel_bytes),
		.devtbl_ready_i  (devtbl_ready),
		.devtbl_rdata_i  (devtbl_rdata),
		.gpio_ready_i    (gpio_ready),
		.gpio_rdata_i    (gpio_rdata),
		.dma_ready_i     (dma_s_ready),
		.dma_rdata_i     (dma_s_rdata),
		.sram_ready_i    (sram_ready),
		.sram_rdata_i    (sram_rdata)
	);

	dma_engine u_dma (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.sel_i       (slv_sel[SLV_DMA]),
		.op_i        (slv_op),
		.addr_i      (slv_addr),
		.wdata_i     (slv_wdata),
		.sel_bytes_i (slv_sel_bytes),
		.ready_o     (dma_s_ready),
		.rdata_o     (dma_s_rdata),
		.m_valid_o   (dma_m_valid),
		.m_op_o      (dma_m_op),
		.m_addr_o    (dma_m_addr),
		.m_wdata_o   (dma_m_wdata),
		.m_sel_o     (dma_m_sel),
		.m_ready_i   (dma_m_ready),
		.m_rdata_i   (dma_m_rdata)
	);

	device_table u_devtbl (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.sel_i       (slv_sel[SLV_DEVTBL]),
		.op_i        (slv_op),
		.addr_i      (slv_addr),
		.ready_o     (devtbl_ready),
		.rdata_o     (devtbl_rdata)
	);

	gpio_port u_gpio (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.sel_i       (slv_sel[SLV_GPIO]),
		.op_i        (slv_op),
		.addr_i      (slv_addr),
		.wdata_i     (slv_wdata),
		.sel_bytes_i (slv_sel_bytes),
		.ready_o     (gpio_ready),
		.rdata_o     (gpio_rdata),
		.gp_i        (gp_i),
		.gp_o        (gp_o)
	);

	sram_slave u_sram (
		.clk100mhz_i (clk100mhz_i),
		.sel_i       (slv_sel[SLV_SRAM]),
		.op_i        (slv_op),
		.addr_i      (slv_addr),
		.wdata_i     (slv_wdata),
		.sel_bytes_i (slv_sel_bytes),
		.ready_o     (sram_ready),
		.rdata_o     (sram_rdata)
	);

endmodule

`default_nettype wire

/* dv/fabric_soc_asserts.sv */
// ##############################
// Handshake and arbitration
// assertions, bound to the top
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module fabric_soc_asserts
	import fabric_soc_pkg::*;
(
	input logic                   clk100mhz_i,
	input logic                   rst_p,
	input logic                   host_valid_i,
	input logic                   host_ready_i,
	input logic [SLAVE_COUNT-1:0] slv_sel_i,
	input logic                   bus_valid_i,
	input logic                   bus_ready_i,
	input bus_op_t                bus_op_i,
	input logic [`ADDR_W-1:0]     bus_addr_i,
	input logic [`GPIO_W-1:0]     gp_out_i
);

	// Ready only answers a request that is still held
	host_ready_needs_valid: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p)
		host_ready_i |-> host_valid_i
	) else $error("host_ready_o high while host_valid_i is low");

	slave_select_onehot: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p)
		$onehot0(slv_sel_i)
	) else $error("more than one slave select high");

	// An ownership change before ready would move the shared request
	owner_held_until_ready: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p)
		(bus_valid_i && !bus_ready_i) |=>
			(bus_valid_i && $stable(bus_addr_i) && $stable(bus_op_i))
	) else $error("bus request changed before bus ready");

	gpio_out_zero_after_reset: assert property (
		@(posedge clk100mhz_i)
		$fell(rst_p) |-> (gp_out_i == '0)
	) else $error("gp_o not zero after reset");

endmodule

bind fabric_soc fabric_soc_asserts u_asserts (
	.clk100mhz_i  (clk100mhz_i),
	.rst_p        (rst_p),
	.host_valid_i (host_valid_i),
	.host_ready_i (host_ready_o),
	.slv_sel_i    (slv_sel),
	.bus_valid_i  (bus_valid),
	.bus_ready_i  (bus_ready),
	.bus_op_i     (bus_op),
	.bus_addr_i   (bus_addr),
	.gp_out_i     (gp_o)
);

`default_nettype wire

/* dv/fabric_soc_tb.sv */
// ##############################
// Bus fabric testbench
// Host bus tasks, value check
// and directed tests
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "fabric_soc_macros.svh"

module fabric_soc_tb
	import fabric_soc_pkg::*;
();

	localparam int WAIT_LIMIT = 100;
	localparam int POLL_LIMIT = 200;
	localparam int SRAM_WORDS = 8;
	localparam int DMA_WORDS  = 12;

	// SRAM regions used by the DMA test
	localparam logic [`ADDR_W-1:0] DMA_SRC  = `ADDR_W'(`SRAM_BASE + 16'h0100);
	localparam logic [`ADDR_W-1:0] DMA_DST  = `ADDR_W'(`SRAM_BASE + 16'h0200);
	localparam logic [`ADDR_W-1:0] DMA_SIDE = `ADDR_W'(`SRAM_BASE + 16'h0300);

	logic               clk100mhz_i;
	logic               rst_p;
	logic               host_valid_i;
	bus_op_t            host_op_i;
	logic [`ADDR_W-1:0] host_addr_i;
	logic [`DATA_W-1:0] host_wdata_i;
	logic [`SEL_W-1:0]  host_sel_i;
	logic               host_ready_o;
	logic [`DATA_W-1:0] host_rdata_o;
	logic [`GPIO_W-1:0] gp_i;
	logic [`GPIO_W-1:0] gp_o;
	int                 seed;

	fabric_soc dut0 (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.host_valid_i (host_valid_i),
		.host_op_i    (host_op_i),
		.host_addr_i  (host_addr_i),
		.host_wdata_i (host_wdata_i),
		.host_sel_i   (host_sel_i),
		.host_ready_o (host_ready_o),
		.host_rdata_o (host_rdata_o),
		.gp_i         (gp_i),
		.gp_o         (gp_o)
	);

	always #5 clk100mhz_i = ~clk100mhz_i;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_eq(
		input string              name,
		input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] exp
	);
		if (got !== exp) begin
			abort_run($sformatf("ERROR at %0t: %s is 0x%08h, expected 0x%08h",
				$time, name, got, exp));
		end
	endtask

	// Waits for the ready pulse, then drops the request on the next edge
	task automatic finish_request(output logic [`DATA_W-1:0] data);
		int cycles;
		cycles = 0;
		@(negedge clk100mhz_i);
		while (!host_ready_o) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run("Timed out waiting for host_ready_o");
			end
			@(negedge clk100mhz_i);
		end
		data = host_rdata_o;
		@(posedge clk100mhz_i);
		host_valid_i <= 1'b0;
		host_op_i    <= OP_NONE;
	endtask

	task automatic bus_write(
		input logic [`ADDR_W-1:0] addr,
		input logic [`DATA_W-1:0] data,
		input logic [`SEL_W-1:0]  sel
	);
		logic [`DATA_W-1:0] ignored;
		@(posedge clk100mhz_i);
		host_valid_i <= 1'b1;
		host_op_i    <= OP_WRITE;
		host_addr_i  <= addr;
		host_wdata_i <= data;
		host_sel_i   <= sel;
		finish_request(ignored);
	endtask

	task automatic bus_read(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
		@(posedge clk100mhz_i);
		host_valid_i <= 1'b1;
		host_op_i    <= OP_READ;
		host_addr_i  <= addr;
		host_wdata_i <= '0;
		host_sel_i   <= '1;
		finish_request(data);
	endtask

	task automatic test_reset_state();
		@(negedge clk100mhz_i);
		check_eq("host_ready_o", `DATA_W'(host_ready_o), '0);
		check_eq("gp_o", `DATA_W'(gp_o), '0);
	endtask

	task automatic test_device_table();
		logic [`DATA_W-1:0] rd;
		logic [`DATA_W-1:0] exp_id [SLAVE_COUNT];
		logic [`DATA_W-1:0] exp_sz [SLAVE_COUNT];
		exp_id[SLV_DEVTBL]  = `ID_DEVTBL;
		exp_id[SLV_GPIO]    = `ID_GPIO;
		exp_id[SLV_DMA]     = `ID_DMA;
		exp_id[SLV_SRAM]    = `ID_SRAM;
		exp_id[SLV_INVALID] = `ID_INVALID;
		exp_sz[SLV_DEVTBL]  = `MAPSZ_REG;
		exp_sz[SLV_GPIO]    = `MAPSZ_REG;
		exp_sz[SLV_DMA]     = `MAPSZ_REG;
		exp_sz[SLV_SRAM]    = `MAPSZ_SRAM;
		exp_sz[SLV_INVALID] = `MAPSZ_INVALID;
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			bus_read(`ADDR_W'(`DEVTBL_BASE + i), rd);
			check_eq($sformatf("device id word %0d", i), rd, exp_id[i]);
			bus_read(`ADDR_W'(`DEVTBL_BASE + 8 + i), rd);
			check_eq($sformatf("map size word %0d", 8 + i), rd, exp_sz[i]);
		end
	endtask

	task automatic test_sram();
		logic [`DATA_W-1:0] words [SRAM_WORDS];
		logic [`DATA_W-1:0] rd;
		logic [`DATA_W-1:0] new_val;
		logic [`DATA_W-1:0] mask;
		logic [`SEL_W-1:0]  sel;
		for (int i = 0; i < SRAM_WORDS; i++) begin
			words[i] = $random(seed);
			bus_write(`ADDR_W'(`SRAM_BASE + 16'h0010 + i), words[i], '1);
		end
		for (int i = 0; i < SRAM_WORDS; i++) begin
			bus_read(`ADDR_W'(`SRAM_BASE + 16'h0010 + i), rd);
			check_eq($sformatf("sram word %0d", i), rd, words[i]);
		end
		// Partial writes keep the unselected bytes of the earlier word
		for (int i = 0; i < SRAM_WORDS; i++) begin
			new_val = $random(seed);
			sel     = `SEL_W'($random(seed));
			for (int b = 0; b < `SEL_W; b++) begin
				mask[8*b +: 8] = {8{sel[b]}};
			end
			bus_write(`ADDR_W'(`SRAM_BASE + 16'h0010 + i), new_val, sel);
			words[i] = (words[i] & ~mask) | (new_val & mask);
			bus_read(`ADDR_W'(`SRAM_BASE + 16'h0010 + i), rd);
			check_eq($sformatf("sram word %0d after sel %b", i, sel), rd, words[i]);
		end
	endtask

	task automatic test_gpio();
		logic [`DATA_W-1:0] rd;
		logic [`GPIO_W-1:0] out_val;
		logic [`GPIO_W-1:0] in_val;
		int                 tries;
		out_val = `GPIO_W'($random(seed));
		bus_write(`ADDR_W'(`GPIO_BASE + 1), {24'hA5C3E1, out_val}, `SEL_W'(1));
		@(negedge clk100mhz_i);
		check_eq("gp_o", `DATA_W'(gp_o), `DATA_W'(out_val));
		bus_read(`ADDR_W'(`GPIO_BASE + 1), rd);
		check_eq("gpio out register", rd, `DATA_W'(out_val));
		// No low byte select, so the register keeps its value
		bus_write(`ADDR_W'(`GPIO_BASE + 1), ~`DATA_W'(out_val), `SEL_W'(4'b1110));
		@(negedge clk100mhz_i);
		check_eq("gp_o after upper byte write", `DATA_W'(gp_o), `DATA_W'(out_val));
		in_val = ~out_val;
		@(posedge clk100mhz_i);
		gp_i <= in_val;
		tries = 0;
		bus_read(`ADDR_W'(`GPIO_BASE), rd);
		while (rd !== `DATA_W'(in_val)) begin
			tries++;
			if (tries > 10) begin
				abort_run("GPIO input read never matched gp_i within the retry limit");
			end
			bus_read(`ADDR_W'(`GPIO_BASE), rd);
		end
	endtask

	task automatic test_invalid();
		logic [`DATA_W-1:0] rd;
		bus_read(16'h0800, rd);
		check_eq("read of 0x0800", rd, '0);
		bus_read(16'h2000, rd);
		check_eq("read of 0x2000", rd, '0);
		bus_write(16'h0800, $random(seed), '1);
		bus_read(16'h0800, rd);
		check_eq("read of 0x0800 after write", rd, '0);
	endtask

	task automatic test_dma();
		logic [`DATA_W-1:0] src_words [DMA_WORDS];
		logic [`DATA_W-1:0] side_words [SRAM_WORDS];
		logic [`DATA_W-1:0] rd;
		int                 polls;
		for (int i = 0; i < DMA_WORDS; i++) begin
			src_words[i] = $random(seed);
			bus_write(DMA_SRC + `ADDR_W'(i), src_words[i], '1);
			bus_write(DMA_DST + `ADDR_W'(i), {16'hD5D5, DMA_DST + `ADDR_W'(i)}, '1);
		end
		for (int i = 0; i < SRAM_WORDS; i++) begin
			side_words[i] = $random(seed);
			bus_write(DMA_SIDE + `ADDR_W'(i), side_words[i], '1);
		end
		bus_write(`ADDR_W'(`DMA_BASE + 0), `DATA_W'(DMA_SRC), '1);
		bus_write(`ADDR_W'(`DMA_BASE + 1), `DATA_W'(DMA_DST), '1);
		bus_write(`ADDR_W'(`DMA_BASE + 2), `DATA_W'(DMA_WORDS), '1);
		bus_write(`ADDR_W'(`DMA_BASE + 3), `DATA_W'(1), '1);
		bus_read(`ADDR_W'(`DMA_BASE + 3), rd);
		check_eq("dma busy after start", rd, `DATA_W'(1));
		// Host traffic competes with the copy for the bus
		for (int i = 0; i < SRAM_WORDS; i++) begin
			bus_read(DMA_SIDE + `ADDR_W'(i), rd);
			check_eq($sformatf("side word %0d during copy", i), rd, side_words[i]);
		end
		polls = 0;
		rd    = `DATA_W'(1);
		while (rd[0]) begin
			polls++;
			if (polls > POLL_LIMIT) begin
				abort_run("DMA stayed busy beyond the poll limit");
			end
			bus_read(`ADDR_W'(`DMA_BASE + 3), rd);
		end
		for (int i = 0; i < DMA_WORDS; i++) begin
			bus_read(DMA_DST + `ADDR_W'(i), rd);
			check_eq($sformatf("dma destination word %0d", i), rd, src_words[i]);
		end
	endtask

	initial begin
		seed         = 40780;
		clk100mhz_i  = 1'b0;
		rst_p        = 1'b1;
		host_valid_i = 1'b0;
		host_op_i    = OP_NONE;
		host_addr_i  = '0;
		host_wdata_i = '0;
		host_sel_i   = '0;
		gp_i         = '0;
		repeat (2) @(posedge clk100mhz_i);
		rst_p <= 1'b0;
		test_reset_state();
		test_device_table();
		test_sram();
		test_gpio();
		test_invalid();
		test_dma();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* fabric_soc.f */
+incdir+include
design/fabric_soc_pkg.sv
design/bus_arbiter.sv
design/addr_decoder.sv
design/dma_engine.sv
design/device_table.sv
design/gpio_port.sv
design/sram_slave.sv
design/fabric_soc.sv
dv/fabric_soc_asserts.sv
dv/fabric_soc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fabric testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f fabric_soc.f --top-module fabric_soc_tb \
	-o sim_fabric_soc > build.log 2>&1 \
	&& ./obj_dir/sim_fabric_soc > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
